// File: ex_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared widths, ALU function codes and multiplier depth for the
// execute stage. Function encodings follow the Alpha-style decoder
// upstream; codes not listed here produce a zero result.
// mult_stages must be at least 2 and must divide data_w evenly.
//////////////////////////////////////////////////////////////////////

package ex_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////
  localparam int data_w    = 64;  // Operand and result width
  localparam int prf_idx_w = 6;   // Physical register tag
  localparam int rob_idx_w = 5;   // Reorder buffer index
  localparam int func_w    = 5;   // ALU function code

  //////////////////////////////////////////////////////////////////////
  // Function codes
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [func_w-1:0] {
    func_add    = 5'h00,
    func_sub    = 5'h01,
    func_and    = 5'h02,
    func_or     = 5'h04,
    func_xor    = 5'h06,
    func_srl    = 5'h08,  // Shift amount from opb[5:0]
    func_sll    = 5'h09,
    func_mulq   = 5'h0b,  // Low half of product, multiplier only
    func_cmpeq  = 5'h0c,  // Result is 1 or 0
    func_cmpult = 5'h0f   // Unsigned less-than
  } alu_func_t;

  //////////////////////////////////////////////////////////////////////
  // Multiplier
  //////////////////////////////////////////////////////////////////////
  localparam int mult_stages = 4;

  // Bits of the multiplier consumed per pipeline stage
  localparam int mult_chunk_w = data_w / mult_stages;

  // Shift amount field of operand b
  localparam int shamt_w = 6;

endpackage

// File: ex_alu.sv
//////////////////////////////////////////////////////////////////////
// Single-cycle integer ALU with a one-entry output register.
// Function is evaluated combinationally from the issue fields and the
// result holds in the register until out_ready takes it.
// Multiplies are never routed here and fall into the zero result.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ex_alu (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  ex_pkg::alu_func_t            func,
  input  logic [ex_pkg::data_w-1:0]    opa,
  input  logic [ex_pkg::data_w-1:0]    opb,
  input  logic [ex_pkg::prf_idx_w-1:0] pdest,
  input  logic [ex_pkg::rob_idx_w-1:0] rob_idx,
  output logic                         out_valid,
  input  logic                         out_ready,
  output logic [ex_pkg::data_w-1:0]    out_value,
  output logic [ex_pkg::prf_idx_w-1:0] out_pdest,
  output logic [ex_pkg::rob_idx_w-1:0] out_rob_idx
);

  import ex_pkg::*;

  logic [data_w-1:0]  result;
  logic [shamt_w-1:0] shamt;

  assign shamt = opb[shamt_w-1:0];

  // Function evaluation
  always_comb
  begin
    case (func)
      func_add:    result = opa + opb;
      func_sub:    result = opa - opb;     // Wraps modulo 2^64
      func_and:    result = opa & opb;
      func_or:     result = opa | opb;
      func_xor:    result = opa ^ opb;
      func_sll:    result = opa << shamt;
      func_srl:    result = opa >> shamt;  // Logical, zero fill
      func_cmpeq:  result = data_w'(opa == opb);
      func_cmpult: result = data_w'(opa < opb);
      default:     result = '0;
    endcase
  end

  // Register has room when empty or draining this edge
  assign in_ready = ~out_valid | out_ready;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      out_valid <= 1'b0;
    end
    else if (in_ready)
    begin
      out_valid <= in_valid;
    end
  end

  // Result and tags
  always_ff @(posedge clock)
  begin
    if (in_valid && in_ready)
    begin
      out_value   <= result;
      out_pdest   <= pdest;
      out_rob_idx <= rob_idx;
    end
  end

endmodule

// File: ex_mult.sv
//////////////////////////////////////////////////////////////////////
// Pipelined multiplier returning the low data_w bits of opa * opb.
// Each stage adds one mult_chunk_w slice of opb times the shifted opa.
// The whole pipe freezes while the last stage holds an untaken result,
// so in_ready is low then. Results leave in issue order.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ex_mult (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  logic [ex_pkg::data_w-1:0]    opa,
  input  logic [ex_pkg::data_w-1:0]    opb,
  input  logic [ex_pkg::prf_idx_w-1:0] pdest,
  input  logic [ex_pkg::rob_idx_w-1:0] rob_idx,
  output logic                         out_valid,
  input  logic                         out_ready,
  output logic [ex_pkg::data_w-1:0]    out_value,
  output logic [ex_pkg::prf_idx_w-1:0] out_pdest,
  output logic [ex_pkg::rob_idx_w-1:0] out_rob_idx
);

  import ex_pkg::*;

  localparam int last = mult_stages - 1;

  logic                 stage_valid [mult_stages];
  logic [data_w-1:0]    stage_prod  [mult_stages];  // Partial product so far
  logic [prf_idx_w-1:0] stage_pdest [mult_stages];
  logic [rob_idx_w-1:0] stage_rob   [mult_stages];

  // Operands still needed by later stages, pre-shifted
  logic [data_w-1:0]    stage_mcand  [mult_stages-1];
  logic [data_w-1:0]    stage_mplier [mult_stages-1];

  logic advance;

  assign advance  = ~stage_valid[last] | out_ready;
  assign in_ready = advance;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int s = 0; s < mult_stages; s++)
        stage_valid[s] <= 1'b0;
    end
    else if (advance)
    begin
      stage_valid[0] <= in_valid;
      for (int s = 1; s < mult_stages; s++)
        stage_valid[s] <= stage_valid[s-1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (advance)
    begin
      // First slice straight from the issue operands
      stage_prod[0]   <= opa * opb[mult_chunk_w-1:0];
      stage_mcand[0]  <= opa << mult_chunk_w;
      stage_mplier[0] <= opb >> mult_chunk_w;
      stage_pdest[0]  <= pdest;
      stage_rob[0]    <= rob_idx;

      for (int s = 1; s < mult_stages; s++)
      begin
        stage_prod[s]  <= stage_prod[s-1] +
                          stage_mcand[s-1] * stage_mplier[s-1][mult_chunk_w-1:0];
        stage_pdest[s] <= stage_pdest[s-1];
        stage_rob[s]   <= stage_rob[s-1];
      end

      for (int s = 1; s < mult_stages - 1; s++)
      begin
        stage_mcand[s]  <= stage_mcand[s-1] << mult_chunk_w;
        stage_mplier[s] <= stage_mplier[s-1] >> mult_chunk_w;
      end
    end
  end

  assign out_valid   = stage_valid[last];
  assign out_value   = stage_prod[last];
  assign out_pdest   = stage_pdest[last];
  assign out_rob_idx = stage_rob[last];

endmodule

// File: ex_cdb_arbiter.sv
//////////////////////////////////////////////////////////////////////
// Fixed-priority merge of the ALU and multiplier results onto one
// registered CDB port. The multiplier always wins a tie, so a steady
// stream of multiplies can hold the ALU off the bus.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ex_cdb_arbiter (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         alu_valid,
  output logic                         alu_ready,
  input  logic [ex_pkg::data_w-1:0]    alu_value,
  input  logic [ex_pkg::prf_idx_w-1:0] alu_pdest,
  input  logic [ex_pkg::rob_idx_w-1:0] alu_rob_idx,
  input  logic                         mult_valid,
  output logic                         mult_ready,
  input  logic [ex_pkg::data_w-1:0]    mult_value,
  input  logic [ex_pkg::prf_idx_w-1:0] mult_pdest,
  input  logic [ex_pkg::rob_idx_w-1:0] mult_rob_idx,
  output logic                         cdb_valid,
  input  logic                         cdb_ready,
  output logic [ex_pkg::data_w-1:0]    cdb_value,
  output logic [ex_pkg::prf_idx_w-1:0] cdb_pdest,
  output logic [ex_pkg::rob_idx_w-1:0] cdb_rob_idx
);

  import ex_pkg::*;

  logic                 room;       // CDB register empty or draining
  logic [data_w-1:0]    sel_value;
  logic [prf_idx_w-1:0] sel_pdest;
  logic [rob_idx_w-1:0] sel_rob_idx;

  assign room = ~cdb_valid | cdb_ready;

  // Only the source actually taken sees ready
  assign mult_ready = room;
  assign alu_ready  = room & ~mult_valid;

  assign sel_value   = mult_valid ? mult_value   : alu_value;
  assign sel_pdest   = mult_valid ? mult_pdest   : alu_pdest;
  assign sel_rob_idx = mult_valid ? mult_rob_idx : alu_rob_idx;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      cdb_valid <= 1'b0;
    end
    else if (room)
    begin
      cdb_valid <= mult_valid | alu_valid;
    end
  end

  // Payload holds while the consumer stalls
  always_ff @(posedge clock)
  begin
    if (room && (mult_valid || alu_valid))
    begin
      cdb_value   <= sel_value;
      cdb_pdest   <= sel_pdest;
      cdb_rob_idx <= sel_rob_idx;
    end
  end

endmodule

// File: ex_stage.sv
//////////////////////////////////////////////////////////////////////
// Execute stage top. Steers each issued instruction to the ALU or the
// multiplier by function code and merges both onto one CDB port.
// The issue source must hold its fields while issue_ready is low.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ex_stage (
  input  logic                         clock,
  input  logic                         reset,
  // Issue side
  input  logic                         issue_valid,
  output logic                         issue_ready,
  input  logic [ex_pkg::func_w-1:0]    issue_func,
  input  logic [ex_pkg::data_w-1:0]    issue_opa,
  input  logic [ex_pkg::data_w-1:0]    issue_opb,
  input  logic [ex_pkg::prf_idx_w-1:0] issue_pdest,
  input  logic [ex_pkg::rob_idx_w-1:0] issue_rob_idx,
  // Common data bus
  output logic                         cdb_valid,
  input  logic                         cdb_ready,
  output logic [ex_pkg::data_w-1:0]    cdb_value,
  output logic [ex_pkg::prf_idx_w-1:0] cdb_pdest,
  output logic [ex_pkg::rob_idx_w-1:0] cdb_rob_idx
);

  import ex_pkg::*;

  alu_func_t            alu_func;
  logic                 is_mult;
  logic                 alu_in_valid, alu_in_ready;
  logic                 mult_in_valid, mult_in_ready;

  logic                 alu_out_valid, alu_out_ready;
  logic [data_w-1:0]    alu_out_value;
  logic [prf_idx_w-1:0] alu_out_pdest;
  logic [rob_idx_w-1:0] alu_out_rob_idx;

  logic                 mult_out_valid, mult_out_ready;
  logic [data_w-1:0]    mult_out_value;
  logic [prf_idx_w-1:0] mult_out_pdest;
  logic [rob_idx_w-1:0] mult_out_rob_idx;

  //////////////////////////////////////////////////////////////////////
  // Issue steering
  //////////////////////////////////////////////////////////////////////
  assign alu_func = alu_func_t'(issue_func);
  assign is_mult  = (alu_func == func_mulq);

  assign alu_in_valid  = issue_valid & ~is_mult;
  assign mult_in_valid = issue_valid & is_mult;
  assign issue_ready   = is_mult ? mult_in_ready : alu_in_ready;

  ex_alu alu_i (
    .clock(clock), .reset(reset),
    .in_valid(alu_in_valid), .in_ready(alu_in_ready),
    .func(alu_func), .opa(issue_opa), .opb(issue_opb),
    .pdest(issue_pdest), .rob_idx(issue_rob_idx),
    .out_valid(alu_out_valid), .out_ready(alu_out_ready),
    .out_value(alu_out_value), .out_pdest(alu_out_pdest),
    .out_rob_idx(alu_out_rob_idx)
  );

  ex_mult mult_i (
    .clock(clock), .reset(reset),
    .in_valid(mult_in_valid), .in_ready(mult_in_ready),
    .opa(issue_opa), .opb(issue_opb),
    .pdest(issue_pdest), .rob_idx(issue_rob_idx),
    .out_valid(mult_out_valid), .out_ready(mult_out_ready),
    .out_value(mult_out_value), .out_pdest(mult_out_pdest),
    .out_rob_idx(mult_out_rob_idx)
  );

  ex_cdb_arbiter cdb_arb_i (
    .clock(clock), .reset(reset),
    .alu_valid(alu_out_valid), .alu_ready(alu_out_ready),
    .alu_value(alu_out_value), .alu_pdest(alu_out_pdest),
    .alu_rob_idx(alu_out_rob_idx),
    .mult_valid(mult_out_valid), .mult_ready(mult_out_ready),
    .mult_value(mult_out_value), .mult_pdest(mult_out_pdest),
    .mult_rob_idx(mult_out_rob_idx),
    .cdb_valid(cdb_valid), .cdb_ready(cdb_ready),
    .cdb_value(cdb_value), .cdb_pdest(cdb_pdest), .cdb_rob_idx(cdb_rob_idx)
  );

endmodule

// File: ex_stage_chk.sv
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the issue and CDB handshakes of ex_stage.
// Bound into every ex_stage instance and idle while reset is high.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ex_stage_chk (
  input logic                         clock,
  input logic                         reset,
  input logic                         issue_valid,
  input logic                         issue_ready,
  input logic [ex_pkg::func_w-1:0]    issue_func,
  input logic [ex_pkg::data_w-1:0]    issue_opa,
  input logic [ex_pkg::data_w-1:0]    issue_opb,
  input logic [ex_pkg::prf_idx_w-1:0] issue_pdest,
  input logic [ex_pkg::rob_idx_w-1:0] issue_rob_idx,
  input logic                         cdb_valid,
  input logic                         cdb_ready,
  input logic [ex_pkg::data_w-1:0]    cdb_value,
  input logic [ex_pkg::prf_idx_w-1:0] cdb_pdest,
  input logic [ex_pkg::rob_idx_w-1:0] cdb_rob_idx
);

  int fail_count = 0;  // Failed assertions so far

  // Stalled CDB result holds its payload
  assert property (@(posedge clock) disable iff (reset)
    cdb_valid && !cdb_ready |=> cdb_valid && $stable({cdb_value, cdb_pdest, cdb_rob_idx}))
  else
  begin
    fail_count++;
    $error("CDB payload changed while cdb_ready was low");
  end

  assert property (@(posedge clock) disable iff (reset)
    issue_valid && !issue_ready |=> issue_valid &&
      $stable({issue_func, issue_opa, issue_opb, issue_pdest, issue_rob_idx}))
  else
  begin
    fail_count++;
    $error("Issue fields changed while issue_ready was low");
  end

  // No unknowns on handshakes, nor on the payload it qualifies
  assert property (@(posedge clock) disable iff (reset)
    !$isunknown({issue_ready, cdb_valid}) &&
    (!cdb_valid || !$isunknown({cdb_value, cdb_pdest, cdb_rob_idx})))
  else
  begin
    fail_count++;
    $error("Unknown value on an ex_stage output after reset");
  end

endmodule

bind ex_stage ex_stage_chk chk_i (.*);

// File: tb_ex_stage.sv
//////////////////////////////////////////////////////////////////////
// Trace-driven testbench for ex_stage. Reads ex_trace.txt relative to
// the project root, so the simulator must run from there.
// Trace rob_idx values must be unique since the scoreboard uses them.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_ex_stage;

  import ex_pkg::*;

  localparam int num_ops     = 28;
  localparam int fields      = 6;    // func opa opb pdest rob_idx expected
  localparam int hold_start  = 22;   // First entry issued with the CDB held off
  localparam int wait_limit  = 50;
  localparam int drain_limit = 300;
  localparam int hold_limit  = 4;    // Stalled cycles that count as blocked
  localparam int rob_n       = 2 ** rob_idx_w;

  logic                 clock, reset, issue_valid, issue_ready, cdb_valid, cdb_ready;
  logic [func_w-1:0]    issue_func;
  logic [data_w-1:0]    issue_opa, issue_opb, cdb_value;
  logic [prf_idx_w-1:0] issue_pdest, cdb_pdest;
  logic [rob_idx_w-1:0] issue_rob_idx, cdb_rob_idx;

  logic [data_w-1:0]    trace_mem [0:num_ops*fields-1];

  // Scoreboard keyed by rob_idx, plus issue order per unit
  logic [data_w-1:0]    exp_value  [rob_n];
  logic [prf_idx_w-1:0] exp_pdest  [rob_n];
  logic                 pending    [rob_n];
  logic                 is_mult_op [rob_n];
  logic [rob_idx_w-1:0] alu_order  [$];
  logic [rob_idx_w-1:0] mult_order [$];

  int          check_errors, timeout_errors, outstanding;
  logic [31:0] issue_rng, cdb_rng;
  logic        hold_cdb, block_seen;

  ex_stage dut_i (
    .clock(clock), .reset(reset),
    .issue_valid(issue_valid), .issue_ready(issue_ready), .issue_func(issue_func),
    .issue_opa(issue_opa), .issue_opb(issue_opb),
    .issue_pdest(issue_pdest), .issue_rob_idx(issue_rob_idx),
    .cdb_valid(cdb_valid), .cdb_ready(cdb_ready), .cdb_value(cdb_value),
    .cdb_pdest(cdb_pdest), .cdb_rob_idx(cdb_rob_idx)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_mismatch(input string name, input logic [data_w-1:0] got,
                                 input logic [data_w-1:0] expected);
    check_errors++;
    $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, expected);
  endtask

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Consumer back-pressure, low on about a third of cycles
  always @(posedge clock)
  begin
    #1;
    cdb_rng   = lcg_next(cdb_rng);
    cdb_ready = hold_cdb ? 1'b0 : (cdb_rng[31:16] % 3 != 0);
  end

  //////////////////////////////////////////////////////////////////////
  // CDB monitor, sampled mid-cycle where inputs and flops are settled
  //////////////////////////////////////////////////////////////////////
  always @(negedge clock)
  begin
    if (!reset && cdb_valid && cdb_ready)
      check_result();
  end

  task automatic check_result();
    logic [rob_idx_w-1:0] rob;
    logic [rob_idx_w-1:0] head;
    rob = cdb_rob_idx;
    assert (pending[rob] === 1'b1)
    else
    begin
      check_errors++;
      $display("CDB carried rob_idx %0d that was not in flight at %0t ns", rob, $time);
    end
    if (pending[rob] === 1'b1)
    begin
      assert (cdb_pdest === exp_pdest[rob]) else report_mismatch("cdb_pdest", cdb_pdest,
                                                                  exp_pdest[rob]);
      assert (cdb_value === exp_value[rob]) else report_mismatch("cdb_value", cdb_value,
                                                                  exp_value[rob]);
      head = is_mult_op[rob] ? mult_order.pop_front() : alu_order.pop_front();
      assert (rob === head) else report_mismatch("cdb_rob_idx order", rob, head);
      pending[rob] = 1'b0;
      outstanding--;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Issue side
  //////////////////////////////////////////////////////////////////////
  task automatic record_issue(input int base);
    logic [rob_idx_w-1:0] rob;
    rob             = trace_mem[base+4][rob_idx_w-1:0];
    exp_pdest[rob]  = trace_mem[base+3][prf_idx_w-1:0];
    exp_value[rob]  = trace_mem[base+5];
    is_mult_op[rob] = (trace_mem[base][func_w-1:0] == func_mulq);
    pending[rob]    = 1'b1;
    outstanding++;
    if (is_mult_op[rob])
      mult_order.push_back(rob);
    else
      alu_order.push_back(rob);
  endtask

  task automatic issue_op(input int idx);
    int base;
    int cycles;
    base = idx * fields;
    @(posedge clock);
    #1;
    issue_valid   = 1'b1;
    issue_func    = trace_mem[base][func_w-1:0];
    issue_opa     = trace_mem[base+1];
    issue_opb     = trace_mem[base+2];
    issue_pdest   = trace_mem[base+3][prf_idx_w-1:0];
    issue_rob_idx = trace_mem[base+4][rob_idx_w-1:0];
    cycles = 0;
    @(negedge clock);
    while (!issue_ready && cycles < wait_limit)
    begin
      cycles++;
      if (hold_cdb && cycles >= hold_limit)
      begin
        block_seen = 1'b1;
        hold_cdb   = 1'b0;    // Release the CDB so everything drains
      end
      @(negedge clock);
    end
    if (issue_ready)
      record_issue(base);
    else
    begin
      timeout_errors++;
      $display("Timeout: trace entry %0d was never accepted", idx);
    end
  endtask

  task automatic idle_cycles(input int n);
    @(posedge clock);
    #1;
    issue_valid = 1'b0;
    repeat (n - 1) @(posedge clock);
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (outstanding > 0 && cycles < drain_limit)
    begin
      @(negedge clock);
      cycles++;
    end
    if (outstanding > 0)
    begin
      timeout_errors++;
      $display("Timeout: %0d results never appeared on the CDB", outstanding);
    end
  endtask

  initial
  begin
    reset = 1'b1;
    issue_valid = 1'b0;
    issue_func = '0;
    issue_opa = '0;
    issue_opb = '0;
    issue_pdest = '0;
    issue_rob_idx = '0;
    cdb_ready = 1'b0;
    hold_cdb = 1'b0;
    block_seen = 1'b0;
    check_errors = 0;
    timeout_errors = 0;
    outstanding = 0;
    issue_rng = 32'h35015208;
    cdb_rng = lcg_next(32'h35015208);
    for (int r = 0; r < rob_n; r++)
      pending[r] = 1'b0;
    $readmemh("ex_trace.txt", trace_mem);

    repeat (8) @(posedge clock);
    #1 reset = 1'b0;
    @(negedge clock);
    assert (cdb_valid === 1'b0) else report_mismatch("cdb_valid", cdb_valid, 0);
    assert (issue_ready === 1'b1) else report_mismatch("issue_ready", issue_ready, 1);

    // ALU run then multiply run, with random idles and stalls
    for (int i = 0; i < hold_start; i++)
    begin
      issue_rng = lcg_next(issue_rng);
      if (issue_rng[31:30] == 2'b00)
        idle_cycles(issue_rng[29:28] + 1);
      issue_op(i);
    end
    idle_cycles(1);
    wait_drain();

    // Mixed tail back to back with the CDB held off
    hold_cdb = 1'b1;
    for (int i = hold_start; i < num_ops; i++)
      issue_op(i);
    idle_cycles(1);
    hold_cdb = 1'b0;
    wait_drain();
    assert (block_seen)
    else
    begin
      check_errors++;
      $display("issue_ready never dropped while cdb_ready was held low");
    end

    $display("Errors: %0d check, %0d timeout, %0d assertion", check_errors, timeout_errors,
             dut_i.chk_i.fail_count);
    if (check_errors == 0 && timeout_errors == 0 && dut_i.chk_i.fail_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: verilog.f
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_cdb_arbiter.sv
ex_stage.sv
ex_stage_chk.sv
tb_ex_stage.sv

// File: ex_trace.txt
// One instruction per line, all fields in hex:
// func opa opb pdest rob_idx expected
00 ffffffffffffffff 0000000000000001 01 00 0000000000000000
00 00000000ffffffff 0000000000000001 02 01 0000000100000000
01 0000000000000000 0000000000000001 03 02 ffffffffffffffff
01 0000000000000064 0000000000000023 04 03 0000000000000041
02 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 05 04 f000f000f000f000
04 f0f0f0f0f0f0f0f0 0f0f0f0f00000000 06 05 fffffffff0f0f0f0
06 aaaaaaaaaaaaaaaa ffffffff00000000 07 06 55555555aaaaaaaa
09 0000000000000001 000000000000003f 08 07 8000000000000000
09 0000000000000001 0000000000000040 09 08 0000000000000001
08 8000000000000000 000000000000003f 0a 09 0000000000000001
08 123456789abcdef0 0000000000000004 0b 0a 0123456789abcdef
0c 0123456789abcdef 0123456789abcdef 0c 0b 0000000000000001
0c 0123456789abcdef 0123456789abcdee 0d 0c 0000000000000000
0f 0000000000000001 ffffffffffffffff 0e 0d 0000000000000001
0f ffffffffffffffff 0000000000000001 0f 0e 0000000000000000
03 1111111111111111 2222222222222222 10 0f 0000000000000000
0b 0000000000000007 0000000000000006 11 10 000000000000002a
0b ffffffffffffffff ffffffffffffffff 12 11 0000000000000001
0b 0000000100000000 0000000100000000 13 12 0000000000000000
0b 00000000ffffffff 00000000ffffffff 14 13 fffffffe00000001
0b 123456789abcdef0 0000000000000010 15 14 23456789abcdef00
0b ffffffffffffffff 0000000000000003 16 15 fffffffffffffffd
00 0000000000000005 0000000000000007 17 16 000000000000000c
0b 0000000000000003 0000000000000003 18 17 0000000000000009
01 0000000000000010 0000000000000001 19 18 000000000000000f
0b 8000000000000000 0000000000000002 1a 19 0000000000000000
02 00000000000000ff 000000000000000f 1b 1a 000000000000000f
00 7fffffffffffffff 0000000000000001 1c 1b 8000000000000000
